//--- hdl/execPkg.sv
`default_nettype none

package execPkg;

    localparam int dataWidth    = 32;
    localparam int tagWidth     = 4;
    localparam int memDepth     = 64;
    localparam int memAddrWidth = $clog2(memDepth); // word index.

    localparam logic [dataWidth-1:0] pcStep = 4; // one instruction.

    typedef enum logic [4:0] {
        LUI,
        AUIPC,
        JAL,
        JALR,
        BEQ,
        BNE,
        BLT,
        BGE,
        BLTU,
        BGEU,
        ADDI,
        SLTI,
        SLTIU,
        XORI,
        ORI,
        ANDI,
        SLLI,
        SRLI,
        SRAI,
        ADD,
        SUB,
        SLL,
        SLT,
        SLTU,
        XOR,
        SRL,
        SRA,
        OR,
        AND,
        LW,
        SW
    } execOp;

    // steers dispatch between the two units.
    function automatic logic isMemOp(input execOp op);
        return (op == LW) || (op == SW);
    endfunction

endpackage

`default_nettype wire

//--- hdl/aluExecute.sv
`timescale 1ns/1ps
`default_nettype none

module aluExecute (
    input  wire                           clk,
    input  wire                           rst,
    input  wire                           en,
    input  wire execPkg::execOp           op,
    input  wire [execPkg::dataWidth-1:0]  pc,
    input  wire [execPkg::dataWidth-1:0]  imm,
    input  wire [execPkg::tagWidth-1:0]   tag,
    input  wire [execPkg::dataWidth-1:0]  rs1,
    input  wire [execPkg::dataWidth-1:0]  rs2,
    output logic                          req,
    input  wire                           grant,
    output logic                          busy,
    output logic [execPkg::tagWidth-1:0]  resTag,
    output logic [execPkg::dataWidth-1:0] resData,
    output logic                          resTaken,
    output logic [execPkg::dataWidth-1:0] resNextPc
);

    logic                          accept;
    logic [execPkg::dataWidth-1:0] seqPc;
    logic [execPkg::dataWidth-1:0] branchPc;
    logic                          branchCond;
    logic [execPkg::dataWidth-1:0] nextData;
    logic                          nextTaken;
    logic [execPkg::dataWidth-1:0] nextPc;

    assign accept   = en && !req;
    assign busy     = req; // held result not yet on the bus.
    assign seqPc    = pc + execPkg::pcStep;
    assign branchPc = pc + imm;

    always_comb begin
        nextData   = '0;
        nextTaken  = 1'b0;
        nextPc     = seqPc;
        branchCond = 1'b0;
        case (op)
            execPkg::LUI:   nextData = imm;
            execPkg::AUIPC: nextData = branchPc;
            execPkg::JAL: begin
                nextData  = seqPc;
                nextTaken = 1'b1; // target already taken at fetch.
            end
            execPkg::JALR: begin
                nextData  = seqPc;
                nextTaken = 1'b1;
                nextPc    = rs1 + imm;
            end
            execPkg::BEQ:   branchCond = (rs1 == rs2);
            execPkg::BNE:   branchCond = (rs1 != rs2);
            execPkg::BLT:   branchCond = ($signed(rs1) < $signed(rs2));
            execPkg::BGE:   branchCond = ($signed(rs1) >= $signed(rs2));
            execPkg::BLTU:  branchCond = (rs1 < rs2);
            execPkg::BGEU:  branchCond = (rs1 >= rs2);
            execPkg::ADDI:  nextData = rs1 + imm;
            execPkg::SLTI:  nextData[0] = ($signed(rs1) < $signed(imm));
            execPkg::SLTIU: nextData[0] = (rs1 < imm); // imm already sign extended.
            execPkg::XORI:  nextData = rs1 ^ imm;
            execPkg::ORI:   nextData = rs1 | imm;
            execPkg::ANDI:  nextData = rs1 & imm;
            execPkg::SLLI:  nextData = rs1 << imm[4:0];
            execPkg::SRLI:  nextData = rs1 >> imm[4:0];
            execPkg::SRAI:  nextData = $signed(rs1) >>> imm[4:0];
            execPkg::ADD:   nextData = rs1 + rs2;
            execPkg::SUB:   nextData = rs1 - rs2;
            execPkg::SLL:   nextData = rs1 << rs2[4:0];
            execPkg::SLT:   nextData[0] = ($signed(rs1) < $signed(rs2));
            execPkg::SLTU:  nextData[0] = (rs1 < rs2);
            execPkg::XOR:   nextData = rs1 ^ rs2;
            execPkg::SRL:   nextData = rs1 >> rs2[4:0];
            execPkg::SRA:   nextData = $signed(rs1) >>> rs2[4:0];
            execPkg::OR:    nextData = rs1 | rs2;
            execPkg::AND:   nextData = rs1 & rs2;
            default: ; // memory ops go to the lsu.
        endcase
        if (branchCond) begin
            nextTaken = 1'b1;
            nextPc    = branchPc;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            req <= 1'b0;
        end else if (accept) begin
            req <= 1'b1;
        end else if (grant) begin
            req <= 1'b0;
        end
    end

    // frozen while the arbiter serves the lsu.
    always_ff @(posedge clk) begin
        if (accept) begin
            resTag    <= tag;
            resData   <= nextData;
            resTaken  <= nextTaken;
            resNextPc <= nextPc;
        end
    end

endmodule

`default_nettype wire

//--- hdl/loadStoreUnit.sv
`timescale 1ns/1ps
`default_nettype none

module loadStoreUnit (
    input  wire                           clk,
    input  wire                           rst,
    input  wire                           en,
    input  wire execPkg::execOp           op,
    input  wire [execPkg::dataWidth-1:0]  imm,
    input  wire [execPkg::tagWidth-1:0]   tag,
    input  wire [execPkg::dataWidth-1:0]  rs1,
    input  wire [execPkg::dataWidth-1:0]  rs2,
    output logic                          req,
    input  wire                           grant,
    output logic                          busy,
    output logic [execPkg::tagWidth-1:0]  resTag,
    output logic [execPkg::dataWidth-1:0] resData
);

    logic [execPkg::dataWidth-1:0]    mem [execPkg::memDepth];
    logic                             accept;
    logic [execPkg::dataWidth-1:0]    effAddr;
    logic                             agValid;
    logic                             agStore;
    logic [execPkg::memAddrWidth-1:0] agIdx;
    logic [execPkg::tagWidth-1:0]     agTag;
    logic [execPkg::dataWidth-1:0]    agData;

    assign effAddr = rs1 + imm;
    assign busy    = agValid || req; // one op at a time keeps program order.
    assign accept  = en && !busy;

    always_ff @(posedge clk) begin
        if (rst) begin
            agValid <= 1'b0;
            req     <= 1'b0;
        end else begin
            agValid <= accept;
            if (agValid && !agStore) begin
                req <= 1'b1;
            end else if (grant) begin
                req <= 1'b0;
            end
        end
    end

    // address stage.
    always_ff @(posedge clk) begin
        if (accept) begin
            agIdx   <= effAddr[execPkg::memAddrWidth+1:2];
            agStore <= (op == execPkg::SW);
            agTag   <= tag;
            agData  <= rs2;
        end
    end

    // memory stage, load result held until granted.
    always_ff @(posedge clk) begin
        if (agValid) begin
            if (agStore) begin
                mem[agIdx] <= agData;
            end else begin
                resData <= mem[agIdx];
                resTag  <= agTag;
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/cdbArbiter.sv
`timescale 1ns/1ps
`default_nettype none

module cdbArbiter (
    input  wire                           clk,
    input  wire                           rst,
    input  wire                           aluReq,
    input  wire [execPkg::tagWidth-1:0]   aluTag,
    input  wire [execPkg::dataWidth-1:0]  aluData,
    input  wire                           aluTaken,
    input  wire [execPkg::dataWidth-1:0]  aluNextPc,
    input  wire                           lsuReq,
    input  wire [execPkg::tagWidth-1:0]   lsuTag,
    input  wire [execPkg::dataWidth-1:0]  lsuData,
    output logic                          aluGrant,
    output logic                          lsuGrant,
    output logic                          cdbEn,
    output logic [execPkg::tagWidth-1:0]  cdbTag,
    output logic [execPkg::dataWidth-1:0] cdbData,
    output logic                          cdbTaken,
    output logic [execPkg::dataWidth-1:0] cdbNextPc
);

    assign lsuGrant = lsuReq; // older memory work first.
    assign aluGrant = aluReq && !lsuReq;

    always_ff @(posedge clk) begin
        if (rst) begin
            cdbEn <= 1'b0;
        end else begin
            cdbEn <= aluGrant || lsuGrant;
        end
    end

    always_ff @(posedge clk) begin
        if (lsuGrant) begin
            cdbTag    <= lsuTag;
            cdbData   <= lsuData;
            cdbTaken  <= 1'b0;
            cdbNextPc <= '0; // loads carry no pc.
        end else if (aluGrant) begin
            cdbTag    <= aluTag;
            cdbData   <= aluData;
            cdbTaken  <= aluTaken;
            cdbNextPc <= aluNextPc;
        end
    end

endmodule

`default_nettype wire

//--- hdl/execCluster.sv
`timescale 1ns/1ps
`default_nettype none

module execCluster (
    input  wire                           clk,
    input  wire                           rst,
    input  wire                           dispEn,
    input  wire execPkg::execOp           dispOp,
    input  wire [execPkg::dataWidth-1:0]  dispPc,
    input  wire [execPkg::dataWidth-1:0]  dispImm,
    input  wire [execPkg::tagWidth-1:0]   dispTag,
    input  wire [execPkg::dataWidth-1:0]  dispRs1,
    input  wire [execPkg::dataWidth-1:0]  dispRs2,
    output logic                          aluBusy,
    output logic                          lsuBusy,
    output logic                          cdbEn,
    output logic [execPkg::tagWidth-1:0]  cdbTag,
    output logic [execPkg::dataWidth-1:0] cdbData,
    output logic                          cdbTaken,
    output logic [execPkg::dataWidth-1:0] cdbNextPc
);

    logic                          aluEn;
    logic                          lsuEn;
    logic                          aluReq;
    logic                          aluGrant;
    logic [execPkg::tagWidth-1:0]  aluTag;
    logic [execPkg::dataWidth-1:0] aluData;
    logic                          aluTaken;
    logic [execPkg::dataWidth-1:0] aluNextPc;
    logic                          lsuReq;
    logic                          lsuGrant;
    logic [execPkg::tagWidth-1:0]  lsuTag;
    logic [execPkg::dataWidth-1:0] lsuData;

    assign aluEn = dispEn && !execPkg::isMemOp(dispOp);
    assign lsuEn = dispEn && execPkg::isMemOp(dispOp);

    aluExecute i_alu (
        .clk(clk),
        .rst(rst),
        .en(aluEn),
        .op(dispOp),
        .pc(dispPc),
        .imm(dispImm),
        .tag(dispTag),
        .rs1(dispRs1),
        .rs2(dispRs2),
        .req(aluReq),
        .grant(aluGrant),
        .busy(aluBusy),
        .resTag(aluTag),
        .resData(aluData),
        .resTaken(aluTaken),
        .resNextPc(aluNextPc)
    );

    loadStoreUnit i_lsu (
        .clk(clk),
        .rst(rst),
        .en(lsuEn),
        .op(dispOp),
        .imm(dispImm),
        .tag(dispTag),
        .rs1(dispRs1),
        .rs2(dispRs2),
        .req(lsuReq),
        .grant(lsuGrant),
        .busy(lsuBusy),
        .resTag(lsuTag),
        .resData(lsuData)
    );

    cdbArbiter i_arb (
        .clk(clk),
        .rst(rst),
        .aluReq(aluReq),
        .aluTag(aluTag),
        .aluData(aluData),
        .aluTaken(aluTaken),
        .aluNextPc(aluNextPc),
        .lsuReq(lsuReq),
        .lsuTag(lsuTag),
        .lsuData(lsuData),
        .aluGrant(aluGrant),
        .lsuGrant(lsuGrant),
        .cdbEn(cdbEn),
        .cdbTag(cdbTag),
        .cdbData(cdbData),
        .cdbTaken(cdbTaken),
        .cdbNextPc(cdbNextPc)
    );

endmodule

`default_nettype wire

//--- sim/tbClock.sv
`timescale 1ns/1ps
`default_nettype none

module tbClock (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk; // 10 ns period.
    end

    initial begin
        rst = 1'b1;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

//--- sim/cdbMonitor.sv
`timescale 1ns/1ps
`default_nettype none

module cdbMonitor (
    input  wire                           clk,
    input  wire                           rst,
    input  wire                           dispEn,
    input  wire execPkg::execOp           dispOp,
    input  wire [execPkg::tagWidth-1:0]   dispTag,
    input  wire [execPkg::dataWidth-1:0]  expData,
    input  wire                           expTaken,
    input  wire [execPkg::dataWidth-1:0]  expNextPc,
    input  wire                           cdbEn,
    input  wire [execPkg::tagWidth-1:0]   cdbTag,
    input  wire [execPkg::dataWidth-1:0]  cdbData,
    input  wire                           cdbTaken,
    input  wire [execPkg::dataWidth-1:0]  cdbNextPc,
    input  wire                           finalCheck,
    output int                            passCount,
    output int                            errorCount,
    output int                            pendingCount
);

    localparam int numTags = 2 ** execPkg::tagWidth;

    logic [execPkg::dataWidth-1:0] wantData [numTags];
    logic                          wantTaken [numTags];
    logic [execPkg::dataWidth-1:0] wantNextPc [numTags];
    logic                          pending [numTags];
    int                            fieldErrs;

    // sampled on the falling edge, away from the dut's register updates.
    always @(negedge clk) begin
        if (rst) begin
            for (int t = 0; t < numTags; t++) pending[t] = 1'b0;
            passCount    = 0;
            errorCount   = 0;
            pendingCount = 0;
        end else begin
            if (cdbEn && !pending[cdbTag]) begin
                $display("result with tag %0d appeared on the CDB but was never dispatched",
                         cdbTag);
                errorCount++;
            end else if (cdbEn) begin
                fieldErrs = 0;
                if (cdbData !== wantData[cdbTag]) begin
                    $display("ERROR tag %0d cdbData got %h expected %h",
                             cdbTag, cdbData, wantData[cdbTag]);
                    fieldErrs++;
                end
                if (cdbTaken !== wantTaken[cdbTag]) begin
                    $display("ERROR tag %0d cdbTaken got %h expected %h",
                             cdbTag, cdbTaken, wantTaken[cdbTag]);
                    fieldErrs++;
                end
                if (cdbNextPc !== wantNextPc[cdbTag]) begin
                    $display("ERROR tag %0d cdbNextPc got %h expected %h",
                             cdbTag, cdbNextPc, wantNextPc[cdbTag]);
                    fieldErrs++;
                end
                if (fieldErrs == 0) begin
                    passCount++;
                    $display("tag %0d ok: data %h taken %0d nextPc %h",
                             cdbTag, cdbData, cdbTaken, cdbNextPc);
                end else begin
                    errorCount += fieldErrs;
                    $display("tag %0d wrong in %0d field(s)", cdbTag, fieldErrs);
                end
                pending[cdbTag] = 1'b0;
            end
            // stores never reach the cdb.
            if (dispEn && dispOp != execPkg::SW) begin
                if (pending[dispTag]) begin
                    $display("tag %0d was dispatched again while still in flight", dispTag);
                    errorCount++;
                end
                pending[dispTag]    = 1'b1;
                wantData[dispTag]   = expData;
                wantTaken[dispTag]  = expTaken;
                wantNextPc[dispTag] = expNextPc;
            end
            pendingCount = 0;
            for (int t = 0; t < numTags; t++) begin
                if (pending[t] && finalCheck) begin
                    $display("tag %0d was dispatched but never appeared on the CDB", t);
                    errorCount++;
                    pending[t] = 1'b0;
                end
                if (pending[t]) pendingCount++;
            end
        end
    end

endmodule

`default_nettype wire

//--- sim/execCluster_chk.sv
`timescale 1ns/1ps
`default_nettype none

module execCluster_chk (
    input wire clk,
    input wire rst,
    input wire cdbEn,
    input wire aluReq,
    input wire aluGrant,
    input wire lsuReq,
    input wire lsuGrant
);

    int failCount = 0; // failed assertions so far.

    cdbQuietInReset: assert property (@(posedge clk) rst |=> !cdbEn)
        else begin $error("cdbEn high after a reset cycle"); failCount++; end

    oneGrant: assert property (@(posedge clk) disable iff (rst) !(aluGrant && lsuGrant))
        else begin $error("both units granted in one cycle"); failCount++; end

    aluReqHeld: assert property (@(posedge clk) disable iff (rst) aluReq && !aluGrant |=> aluReq)
        else begin $error("alu request dropped before grant"); failCount++; end

    lsuReqHeld: assert property (@(posedge clk) disable iff (rst) lsuReq && !lsuGrant |=> lsuReq)
        else begin $error("lsu request dropped before grant"); failCount++; end

endmodule

`default_nettype wire

//--- sim/tbExecCluster.sv
`timescale 1ns/1ps
`default_nettype none

module tbExecCluster;

    localparam int maxOps   = 64;
    localparam int opFields = 9; // words per stimulus line.

    logic                          clk;
    logic                          rst;
    logic                          dispEn;
    execPkg::execOp                dispOp;
    logic [execPkg::dataWidth-1:0] dispPc;
    logic [execPkg::dataWidth-1:0] dispImm;
    logic [execPkg::tagWidth-1:0]  dispTag;
    logic [execPkg::dataWidth-1:0] dispRs1;
    logic [execPkg::dataWidth-1:0] dispRs2;
    logic                          aluBusy;
    logic                          lsuBusy;
    logic                          cdbEn;
    logic [execPkg::tagWidth-1:0]  cdbTag;
    logic [execPkg::dataWidth-1:0] cdbData;
    logic                          cdbTaken;
    logic [execPkg::dataWidth-1:0] cdbNextPc;
    logic [execPkg::dataWidth-1:0] expData;
    logic                          expTaken;
    logic [execPkg::dataWidth-1:0] expNextPc;
    logic                          finalCheck;
    int                            passCount;
    int                            errorCount;
    int                            pendingCount;
    logic [31:0]                   stim [maxOps*opFields];
    logic [31:0]                   lcgState;
    logic                          liveStrobe;
    logic                          liveMem;
    int                            numOps;
    int                            cycleCount = 0;
    int                            cycleLimit = 0;

    tbClock i_clk (.clk(clk), .rst(rst));

    execCluster i_dut (
        .clk(clk), .rst(rst), .dispEn(dispEn), .dispOp(dispOp), .dispPc(dispPc),
        .dispImm(dispImm), .dispTag(dispTag), .dispRs1(dispRs1), .dispRs2(dispRs2),
        .aluBusy(aluBusy), .lsuBusy(lsuBusy), .cdbEn(cdbEn), .cdbTag(cdbTag),
        .cdbData(cdbData), .cdbTaken(cdbTaken), .cdbNextPc(cdbNextPc)
    );

    cdbMonitor i_mon (
        .clk(clk), .rst(rst), .dispEn(dispEn), .dispOp(dispOp), .dispTag(dispTag),
        .expData(expData), .expTaken(expTaken), .expNextPc(expNextPc),
        .cdbEn(cdbEn), .cdbTag(cdbTag), .cdbData(cdbData), .cdbTaken(cdbTaken),
        .cdbNextPc(cdbNextPc), .finalCheck(finalCheck), .passCount(passCount),
        .errorCount(errorCount), .pendingCount(pendingCount)
    );

    bind execCluster execCluster_chk i_chk (
        .clk(clk), .rst(rst), .cdbEn(cdbEn), .aluReq(aluReq), .aluGrant(aluGrant),
        .lsuReq(lsuReq), .lsuGrant(lsuGrant)
    );

    function automatic logic [31:0] lcgNext(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic idleCycles(input int n);
        repeat (n) begin
            @(posedge clk);
            dispEn <= 1'b0;
            liveStrobe = 1'b0;
        end
    endtask

    // a strobe is live for one cycle, so the same unit waits a cycle for busy.
    // memory ops also wait for an idle alu, so a following alu op contends.
    task automatic sendOp(input int k);
        int   b;
        logic isMem;
        b = k * opFields;
        isMem = execPkg::isMemOp(execPkg::execOp'(stim[b][4:0]));
        @(negedge clk);
        while ((liveStrobe && (isMem || !liveMem)) || aluBusy || (isMem && lsuBusy)) begin
            @(posedge clk);
            dispEn <= 1'b0;
            liveStrobe = 1'b0;
            @(negedge clk);
        end
        @(posedge clk);
        dispEn    <= 1'b1;
        dispOp    <= execPkg::execOp'(stim[b][4:0]);
        dispPc    <= stim[b+1];
        dispImm   <= stim[b+2];
        dispTag   <= stim[b+3][execPkg::tagWidth-1:0];
        dispRs1   <= stim[b+4];
        dispRs2   <= stim[b+5];
        expData   <= stim[b+6];
        expTaken  <= stim[b+7][0];
        expNextPc <= stim[b+8];
        liveStrobe = 1'b1;
        liveMem    = isMem;
    endtask

    always @(posedge clk) begin
        cycleCount++;
        if (cycleLimit > 0 && cycleCount > cycleLimit) begin
            $display("timeout after %0d cycles, %0d results still outstanding",
                     cycleCount, pendingCount);
            $display("results ok %0d, errors %0d", passCount, errorCount);
            $display("Regression failed");
            $finish;
        end
    end

    initial begin
        logic isMem;
        logic prevMem;
        int   gap;
        int   assertFails;
        dispEn     = 1'b0;
        dispOp     = execPkg::LUI;
        dispPc     = '0;
        dispImm    = '0;
        dispTag    = '0;
        dispRs1    = '0;
        dispRs2    = '0;
        expData    = '0;
        expTaken   = 1'b0;
        expNextPc  = '0;
        finalCheck = 1'b0;
        liveStrobe = 1'b0;
        liveMem    = 1'b0;
        prevMem    = 1'b0;
        lcgState   = 32'hc0bec57b;
        $readmemh("sim/execStimulus.txt", stim);
        numOps = 0;
        while (numOps < maxOps && stim[numOps*opFields] != 32'hff) numOps++;
        cycleLimit = numOps * 8 + 50;
        @(negedge clk);
        while (rst) @(negedge clk);
        for (int k = 0; k < numOps; k++) begin
            isMem    = execPkg::isMemOp(execPkg::execOp'(stim[k*opFields][4:0]));
            lcgState = lcgNext(lcgState);
            gap      = {30'b0, lcgState[17:16]};
            // a unit change goes back to back, so LW then ALU contends.
            if (k > 0 && isMem == prevMem) idleCycles(gap);
            sendOp(k);
            prevMem = isMem;
        end
        idleCycles(1);
        while (pendingCount != 0) @(posedge clk);
        idleCycles(4); // room for a stray result.
        finalCheck <= 1'b1;
        @(negedge clk);
        @(negedge clk);
        assertFails = i_dut.i_chk.failCount;
        $display("results ok %0d, errors %0d, assertion failures %0d",
                 passCount, errorCount, assertFails);
        if (errorCount == 0 && assertFails == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim/execStimulus.txt
// op pc imm tag rs1 rs2 expData expTaken expNextPc, all hex; op is the execOp code
// a line with op ff ends the list
1e 00000100 00000008 1 00000020 cafef00d 00000000 0 00000000
1e 00000104 0000000c 2 00000020 12345678 00000000 0 00000000
00 00000108 abcde000 3 00000000 00000000 abcde000 0 0000010c
01 0000010c 00001000 4 00000000 00000000 0000110c 0 00000110
02 00000110 00000040 5 00000000 00000000 00000114 1 00000114
03 00000114 00000004 6 00000200 00000000 00000118 1 00000204
1d 00000118 00000008 7 00000020 00000000 cafef00d 0 00000000
13 0000011c 00000000 8 80000010 00000003 80000013 0 00000120
14 00000120 00000000 9 80000010 00000003 8000000d 0 00000124
15 00000124 00000000 a 80000010 00000024 00000100 0 00000128
16 00000128 00000000 b 80000010 00000003 00000001 0 0000012c
17 0000012c 00000000 c 80000010 00000003 00000000 0 00000130
18 00000130 00000000 d f0f0f0f0 ff00ff00 0ff00ff0 0 00000134
19 00000134 00000000 e 80000010 00000004 08000001 0 00000138
1a 00000138 00000000 f 80000010 00000004 f8000001 0 0000013c
1b 0000013c 00000000 0 f0f0f0f0 ff00ff00 fff0fff0 0 00000140
1c 00000140 00000000 1 f0f0f0f0 ff00ff00 f000f000 0 00000144
1d 00000144 0000000c 2 00000020 00000000 12345678 0 00000000
0a 00000148 fffffff0 3 00000005 00000000 fffffff5 0 0000014c
0b 0000014c 00000001 4 ffffffff 00000000 00000001 0 00000150
0c 00000150 00000001 5 ffffffff 00000000 00000000 0 00000154
0d 00000154 ffffffff 6 12345678 00000000 edcba987 0 00000158
0e 00000158 000000f0 7 12345608 00000000 123456f8 0 0000015c
0f 0000015c 000000f0 8 123456ab 00000000 000000a0 0 00000160
10 00000160 00000008 9 12345678 00000000 34567800 0 00000164
11 00000164 00000008 a 87654321 00000000 00876543 0 00000168
12 00000168 00000008 b 87654321 00000000 ff876543 0 0000016c
04 0000016c 00000020 c 00000007 00000007 00000000 1 0000018c
05 00000170 00000020 d 00000007 00000007 00000000 0 00000174
06 00000174 ffffffe0 e 80000010 00000003 00000000 1 00000154
07 00000178 ffffffe0 f 80000010 00000003 00000000 0 0000017c
08 0000017c 00000010 0 80000010 00000003 00000000 0 00000180
09 00000180 00000010 1 80000010 00000003 00000000 1 00000190
ff 00000000 00000000 0 00000000 00000000 00000000 0 00000000

//--- src.f
hdl/execPkg.sv
hdl/aluExecute.sv
hdl/loadStoreUnit.sv
hdl/cdbArbiter.sv
hdl/execCluster.sv
sim/tbClock.sv
sim/cdbMonitor.sv
sim/execCluster_chk.sv
sim/tbExecCluster.sv

//--- run.sh
#!/bin/sh

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

if ! verilator --binary --timing --assert -Wno-fatal -f src.f \
        --top-module tbExecCluster -o simExec; then
    echo "verilator build failed"
    exit 1
fi

if ! ./obj_dir/simExec +verilator+error+limit+100 > sim.log 2>&1; then
    cat sim.log
    echo "simulation exited with an error status"
    exit 1
fi
cat sim.log

if grep -q "Regression failed" sim.log; then
    exit 1
fi
if ! grep -q "Regression passed" sim.log; then
    echo "no verdict found in sim.log"
    exit 1
fi
exit 0
